/* verilog/qla_settings.svh */
//----------------------------------------------------------------------
// qla axis core settings
// widths, axis count and safety limits shared by the RTL
//----------------------------------------------------------------------

`ifndef QLA_SETTINGS_SVH
`define QLA_SETTINGS_SVH

// register bus
`define QLA_NUM_AXES      4         // axis channels 1..4
`define QLA_DATA_WIDTH    32        // register word
`define QLA_ADDR_WIDTH    8         // [7:4] channel, [3:0] offset

// converters, offset binary
`define QLA_CONV_WIDTH    16
`define QLA_MIDSCALE      32768     // zero-current code

// encoder
`define QLA_ENC_WIDTH     24        // counter wraps here

// safety check
`define QLA_SAFETY_MARGIN 256       // allowed excess over 2x command
`define QLA_SAFETY_COUNT  4         // consecutive bad samples to trip

`endif

/* verilog/qla_pkg.sv */
//----------------------------------------------------------------------
// qla package
// register offsets and safety FSM states
//----------------------------------------------------------------------

package qla_pkg;

    // offsets within an axis channel
    typedef enum logic [3:0] {
        OFF_ADC_DATA = 4'd0,    // captured current feedback
        OFF_DAC_CTRL = 4'd1,    // current command
        OFF_ENC_LOAD = 4'd4,    // encoder preload
        OFF_ENC_DATA = 4'd5     // encoder count
    } reg_offset_e;

    // channel 0 status sits on offset 0 as well
    localparam reg_offset_e OFF_STATUS = OFF_ADC_DATA;

    // overcurrent detector states
    typedef enum logic [1:0] {
        SAFE_IDLE     = 2'd0,   // no violation pending
        SAFE_COUNTING = 2'd1,   // run of bad samples
        SAFE_TRIPPED  = 2'd2    // amp disabled, wait for clear
    } safety_state_e;

endpackage

/* verilog/apb_reg_bus.sv */
//----------------------------------------------------------------------
// APB slave for the register map
// decodes phases, checks addresses and selects the channel read word
//----------------------------------------------------------------------

`timescale 1ns/1ns

`include "qla_settings.svh"

module apb_reg_bus (
    input  logic                        sysclk,
    input  logic                        reset,
    input  logic [`QLA_ADDR_WIDTH-1:0]  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`QLA_DATA_WIDTH-1:0]  pwdata,
    input  logic [`QLA_NUM_AXES:0][`QLA_DATA_WIDTH-1:0] chan_rdata,
    output logic [`QLA_DATA_WIDTH-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        reg_wen,
    output logic [`QLA_ADDR_WIDTH-1:0]  reg_waddr,
    output logic [`QLA_DATA_WIDTH-1:0]  reg_wdata,
    output logic [`QLA_ADDR_WIDTH-1:0]  reg_raddr
);

    logic [3:0] chan;       // channel field
    logic [3:0] offset;     // offset field
    logic       setup_q;    // previous cycle was a setup phase
    logic       access;     // qualified access phase
    logic       addr_ok;    // address is mapped

    assign chan   = paddr[`QLA_ADDR_WIDTH-1:4];
    assign offset = paddr[3:0];

    // access counts only after a proper setup cycle
    always_ff @(posedge sysclk) begin
        if (reset)
            setup_q <= 1'b0;
        else
            setup_q <= psel && !penable;
    end

    assign access = psel && penable && setup_q;

    //------------------------------------------------------------------
    // address check per channel kind
    //------------------------------------------------------------------
    always_comb begin
        addr_ok = 1'b0;
        if (chan == 4'd0) begin
            addr_ok = (offset == qla_pkg::OFF_STATUS);   // board regs
        end else if (chan <= `QLA_NUM_AXES) begin
            case (offset)
                qla_pkg::OFF_ADC_DATA,
                qla_pkg::OFF_DAC_CTRL,
                qla_pkg::OFF_ENC_LOAD,
                qla_pkg::OFF_ENC_DATA: addr_ok = 1'b1;
                default:               addr_ok = 1'b0;
            endcase
        end
    end

    assign pready  = 1'b1;                  // no wait states
    assign pslverr = access && !addr_ok;
    assign prdata  = (access && addr_ok) ? chan_rdata[chan] : '0;

    // write bus, one pulse per valid access
    assign reg_wen   = access && pwrite && addr_ok;
    assign reg_waddr = paddr;
    assign reg_wdata = pwdata;
    assign reg_raddr = paddr;

endmodule

/* verilog/board_regs.sv */
//----------------------------------------------------------------------
// channel 0 board registers
// power and amp enables, safety clear pulses, status word
//----------------------------------------------------------------------

`timescale 1ns/1ns

`include "qla_settings.svh"

module board_regs (
    input  logic                        sysclk,
    input  logic                        reset,
    input  logic                        reg_wen,
    input  logic [`QLA_ADDR_WIDTH-1:0]  reg_waddr,
    input  logic [`QLA_DATA_WIDTH-1:0]  reg_wdata,
    input  logic [`QLA_ADDR_WIDTH-1:0]  reg_raddr,
    input  logic [3:0]                  board_id,
    input  logic [`QLA_NUM_AXES-1:0]    amp_disable,
    output logic [`QLA_NUM_AXES-1:0]    amp_enable_req,
    output logic                        pwr_enable,
    output logic [`QLA_NUM_AXES-1:0]    clear_disable,
    output logic [`QLA_DATA_WIDTH-1:0]  rdata
);

    logic wr_status;    // write to the status offset of channel 0

    assign wr_status = reg_wen && (reg_waddr[`QLA_ADDR_WIDTH-1:4] == 4'd0)
                       && (reg_waddr[3:0] == qla_pkg::OFF_STATUS);

    //------------------------------------------------------------------
    // enables and clear pulses
    //------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            amp_enable_req <= '0;
            pwr_enable     <= 1'b0;
            clear_disable  <= '0;
        end else begin
            clear_disable <= '0;                            // single cycle
            if (wr_status) begin
                amp_enable_req <= reg_wdata[`QLA_NUM_AXES-1:0];
                pwr_enable     <= reg_wdata[4];
                // power on clears every axis latch
                clear_disable  <= reg_wdata[`QLA_NUM_AXES-1:0]
                                  | {`QLA_NUM_AXES{reg_wdata[4]}};
            end
        end
    end

    // status: req [3:0], pwr [4], disables [11:8], id [27:24]
    always_comb begin
        rdata = '0;
        if (reg_raddr[3:0] == qla_pkg::OFF_STATUS) begin
            rdata[3:0]   = amp_enable_req;
            rdata[4]     = pwr_enable;
            rdata[11:8]  = amp_disable;
            rdata[27:24] = board_id;
        end
    end

endmodule

/* verilog/quad_encoder.sv */
//----------------------------------------------------------------------
// quadrature encoder
// two-flop sync, x4 decode and preloadable up/down counter
//----------------------------------------------------------------------

`timescale 1ns/1ns

`include "qla_settings.svh"

module quad_encoder (
    input  logic                       sysclk,
    input  logic                       reset,
    input  logic                       enc_a,
    input  logic                       enc_b,
    input  logic                       preload_wen,
    input  logic [`QLA_ENC_WIDTH-1:0]  preload_value,
    output logic [`QLA_ENC_WIDTH-1:0]  count
);

    logic [2:0] a_sr;   // [1:0] sync, [2] previous
    logic [2:0] b_sr;
    logic       step;   // exactly one line changed
    logic       up;     // direction of that change

    always_ff @(posedge sysclk) begin
        if (reset) begin
            a_sr <= '0;
            b_sr <= '0;
        end else begin
            a_sr <= {a_sr[1:0], enc_a};
            b_sr <= {b_sr[1:0], enc_b};
        end
    end

    // a double change is an error and falls out of the xor
    assign step = (a_sr[1] ^ a_sr[2]) ^ (b_sr[1] ^ b_sr[2]);
    assign up   = a_sr[1] ^ b_sr[2];    // A leading B counts up

    //------------------------------------------------------------------
    // counter, wraps at full width
    //------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset)
            count <= '0;
        else if (preload_wen)
            count <= preload_value;     // preload wins over an edge
        else if (step)
            count <= up ? count + 1'b1 : count - 1'b1;
    end

endmodule

/* verilog/safety_check.sv */
//----------------------------------------------------------------------
// overcurrent check
// trips after a run of samples above twice the command plus margin
//----------------------------------------------------------------------

`timescale 1ns/1ns

`include "qla_settings.svh"

module safety_check (
    input  logic                       sysclk,
    input  logic                       reset,
    input  logic [`QLA_CONV_WIDTH-1:0] cur_in,
    input  logic [`QLA_CONV_WIDTH-1:0] dac_in,
    input  logic                       sample_valid,
    input  logic                       clear_disable,
    output logic                       amp_disable
);

    localparam int CW    = `QLA_CONV_WIDTH;
    localparam int CNT_W = $clog2(`QLA_SAFETY_COUNT + 1);
    localparam logic [CW-1:0]    MID     = `QLA_MIDSCALE;
    localparam logic [CW+1:0]    MARGIN  = `QLA_SAFETY_MARGIN;
    localparam logic [CNT_W-1:0] TRIP_AT = `QLA_SAFETY_COUNT - 1;

    qla_pkg::safety_state_e state;
    logic [CNT_W-1:0]       viol_cnt;   // bad samples so far
    logic [CW-1:0]          cur_mag;    // |feedback - mid|
    logic [CW-1:0]          dac_mag;    // |command - mid|
    logic [CW+1:0]          limit;
    logic                   violate;

    assign cur_mag = (cur_in >= MID) ? cur_in - MID : MID - cur_in;
    assign dac_mag = (dac_in >= MID) ? dac_in - MID : MID - dac_in;
    assign limit   = {1'b0, dac_mag, 1'b0} + MARGIN;       // 2x cmd + margin
    assign violate = {2'b00, cur_mag} > limit;

    //------------------------------------------------------------------
    // consecutive violation FSM
    //------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset || clear_disable) begin
            state    <= qla_pkg::SAFE_IDLE;
            viol_cnt <= '0;
        end else if (sample_valid) begin
            case (state)
                qla_pkg::SAFE_IDLE,
                qla_pkg::SAFE_COUNTING: begin
                    if (violate) begin
                        viol_cnt <= viol_cnt + 1'b1;
                        if (viol_cnt == TRIP_AT)
                            state <= qla_pkg::SAFE_TRIPPED;
                        else
                            state <= qla_pkg::SAFE_COUNTING;
                    end else begin
                        viol_cnt <= '0;             // run broken
                        state    <= qla_pkg::SAFE_IDLE;
                    end
                end
                default: state <= state;            // tripped holds until clear
            endcase
        end
    end

    assign amp_disable = (state == qla_pkg::SAFE_TRIPPED);

endmodule

/* verilog/axis_channel.sv */
//----------------------------------------------------------------------
// one motor axis
// current command, feedback capture, encoder, safety and read mux
//----------------------------------------------------------------------

`timescale 1ns/1ns

`include "qla_settings.svh"

module axis_channel #(
    parameter int AXIS_NUM = 1                      // channel number 1..4
) (
    input  logic                        sysclk,
    input  logic                        reset,
    input  logic                        reg_wen,
    input  logic [`QLA_ADDR_WIDTH-1:0]  reg_waddr,
    input  logic [`QLA_DATA_WIDTH-1:0]  reg_wdata,
    input  logic [`QLA_ADDR_WIDTH-1:0]  reg_raddr,
    input  logic [`QLA_CONV_WIDTH-1:0]  cur_fb,
    input  logic                        cur_ready,
    input  logic                        enc_a,
    input  logic                        enc_b,
    input  logic                        clear_disable,
    output logic [`QLA_CONV_WIDTH-1:0]  cur_cmd,
    output logic                        amp_disable,
    output logic [`QLA_DATA_WIDTH-1:0]  rdata
);

    logic                       wr_chan;        // write hits this axis
    logic                       preload_wen;
    logic [`QLA_CONV_WIDTH-1:0] fb_q;           // captured feedback
    logic                       fb_valid;       // fb_q fresh this cycle
    logic [`QLA_ENC_WIDTH-1:0]  preload_q;      // last preload, readable
    logic [`QLA_ENC_WIDTH-1:0]  enc_count;

    assign wr_chan     = reg_wen && (reg_waddr[`QLA_ADDR_WIDTH-1:4] == 4'(AXIS_NUM));
    assign preload_wen = wr_chan && (reg_waddr[3:0] == qla_pkg::OFF_ENC_LOAD);

    //------------------------------------------------------------------
    // command and preload registers
    //------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cur_cmd   <= '0;
            preload_q <= '0;
        end else begin
            if (wr_chan && (reg_waddr[3:0] == qla_pkg::OFF_DAC_CTRL))
                cur_cmd <= reg_wdata[`QLA_CONV_WIDTH-1:0];
            if (preload_wen)
                preload_q <= reg_wdata[`QLA_ENC_WIDTH-1:0];
        end
    end

    // feedback capture on the converter strobe
    always_ff @(posedge sysclk) begin
        if (cur_ready)
            fb_q <= cur_fb;
    end

    always_ff @(posedge sysclk) begin
        if (reset)
            fb_valid <= 1'b0;
        else
            fb_valid <= cur_ready;      // safety sees sample a cycle later
    end

    quad_encoder enc0 (
        .sysclk        (sysclk),
        .reset         (reset),
        .enc_a         (enc_a),
        .enc_b         (enc_b),
        .preload_wen   (preload_wen),
        .preload_value (reg_wdata[`QLA_ENC_WIDTH-1:0]),
        .count         (enc_count)
    );

    safety_check safe0 (
        .sysclk        (sysclk),
        .reset         (reset),
        .cur_in        (fb_q),
        .dac_in        (cur_cmd),
        .sample_valid  (fb_valid),
        .clear_disable (clear_disable),
        .amp_disable   (amp_disable)
    );

    // read mux, all fields zero extended
    always_comb begin
        rdata = '0;
        case (reg_raddr[3:0])
            qla_pkg::OFF_ADC_DATA: rdata[`QLA_CONV_WIDTH-1:0] = fb_q;
            qla_pkg::OFF_DAC_CTRL: rdata[`QLA_CONV_WIDTH-1:0] = cur_cmd;
            qla_pkg::OFF_ENC_LOAD: rdata[`QLA_ENC_WIDTH-1:0]  = preload_q;
            qla_pkg::OFF_ENC_DATA: rdata[`QLA_ENC_WIDTH-1:0]  = enc_count;
            default:               rdata = '0;
        endcase
    end

endmodule

/* verilog/qla_ctrl.sv */
//----------------------------------------------------------------------
// qla axis core top
// APB register bus, board registers and four axis channels
//----------------------------------------------------------------------

`timescale 1ns/1ns

`include "qla_settings.svh"

module qla_ctrl (
    input  logic                        sysclk,
    input  logic                        reset,
    // APB slave
    input  logic [`QLA_ADDR_WIDTH-1:0]  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`QLA_DATA_WIDTH-1:0]  pwdata,
    output logic [`QLA_DATA_WIDTH-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,
    // board and axis I/O
    input  logic [3:0]                  board_id_n,     // rotary switch
    input  logic [`QLA_NUM_AXES-1:0][`QLA_CONV_WIDTH-1:0] cur_fb,
    input  logic                        cur_ready,
    input  logic [`QLA_NUM_AXES-1:0]    enc_a,
    input  logic [`QLA_NUM_AXES-1:0]    enc_b,
    output logic [`QLA_NUM_AXES-1:0][`QLA_CONV_WIDTH-1:0] cur_cmd,
    output logic [`QLA_NUM_AXES-1:0]    amp_enable,
    output logic                        pwr_enable
);

    logic                       reg_wen;
    logic [`QLA_ADDR_WIDTH-1:0] reg_waddr;
    logic [`QLA_DATA_WIDTH-1:0] reg_wdata;
    logic [`QLA_ADDR_WIDTH-1:0] reg_raddr;
    logic [`QLA_NUM_AXES:0][`QLA_DATA_WIDTH-1:0] chan_rdata;   // 0 board, 1..4 axes
    logic [3:0]                 board_id;
    logic [`QLA_NUM_AXES-1:0]   amp_enable_req;
    logic [`QLA_NUM_AXES-1:0]   amp_disable;    // safety latches
    logic [`QLA_NUM_AXES-1:0]   clear_disable;

    assign board_id = ~board_id_n;              // switch is active low

    // amp needs request, power and no safety trip
    assign amp_enable = amp_enable_req & ~amp_disable & {`QLA_NUM_AXES{pwr_enable}};

    apb_reg_bus bus0 (
        .sysclk     (sysclk),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .chan_rdata (chan_rdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .reg_wen    (reg_wen),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .reg_raddr  (reg_raddr)
    );

    board_regs chan0 (
        .sysclk         (sysclk),
        .reset          (reset),
        .reg_wen        (reg_wen),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .reg_raddr      (reg_raddr),
        .board_id       (board_id),
        .amp_disable    (amp_disable),
        .amp_enable_req (amp_enable_req),
        .pwr_enable     (pwr_enable),
        .clear_disable  (clear_disable),
        .rdata          (chan_rdata[0])
    );

    //------------------------------------------------------------------
    // axis channels 1..4
    //------------------------------------------------------------------
    for (genvar i = 0; i < `QLA_NUM_AXES; i++) begin : g_axis
        axis_channel #(.AXIS_NUM(i + 1)) axis (
            .sysclk        (sysclk),
            .reset         (reset),
            .reg_wen       (reg_wen),
            .reg_waddr     (reg_waddr),
            .reg_wdata     (reg_wdata),
            .reg_raddr     (reg_raddr),
            .cur_fb        (cur_fb[i]),
            .cur_ready     (cur_ready),
            .enc_a         (enc_a[i]),
            .enc_b         (enc_b[i]),
            .clear_disable (clear_disable[i]),
            .cur_cmd       (cur_cmd[i]),
            .amp_disable   (amp_disable[i]),
            .rdata         (chan_rdata[i + 1])
        );
    end

endmodule

/* test/tb_qla_model.svh */
//----------------------------------------------------------------------
// qla testbench model
// APB access tasks, check queue and reference functions
//----------------------------------------------------------------------

`ifndef TB_QLA_MODEL_SVH
`define TB_QLA_MODEL_SVH

localparam int APB_TIMEOUT = 20;    // cycles to wait for pready
localparam int MID         = `QLA_MIDSCALE;

// status layout: req [3:0], pwr [4], disables [11:8], id [27:24]
function automatic logic [31:0] exp_status(input logic [3:0] req, input logic pwr,
                                           input logic [3:0] dis, input logic [3:0] id);
    exp_status = {4'h0, id, 12'h000, dis, 3'b000, pwr, req};
endfunction

// forward gray order 00 10 11 01, ab = {a, b}
function automatic int enc_phase(input logic [1:0] ab);
    case (ab)
        2'b00:   enc_phase = 0;
        2'b10:   enc_phase = 1;
        2'b11:   enc_phase = 2;
        default: enc_phase = 3;
    endcase
endfunction

function automatic logic [1:0] ab_of_phase(input int phase);
    case (phase % 4)
        0:       ab_of_phase = 2'b00;
        1:       ab_of_phase = 2'b10;
        2:       ab_of_phase = 2'b11;
        default: ab_of_phase = 2'b01;
    endcase
endfunction

// expected count after the lines move from old_ab to new_ab
function automatic logic [`QLA_ENC_WIDTH-1:0] exp_enc_count(
        input logic [`QLA_ENC_WIDTH-1:0] cnt, input logic [1:0] old_ab,
        input logic [1:0] new_ab);
    int diff;
    diff = (enc_phase(new_ab) - enc_phase(old_ab) + 4) % 4;
    if (diff == 1)
        exp_enc_count = cnt + 1'b1;     // A leads B
    else if (diff == 3)
        exp_enc_count = cnt - 1'b1;
    else
        exp_enc_count = cnt;            // hold or double change
endfunction

// length of the violation run after one more sample
function automatic int next_viol_run(input int run, input int fb, input int cmd);
    int cur_mag;
    int cmd_mag;
    cur_mag = (fb >= MID) ? fb - MID : MID - fb;
    cmd_mag = (cmd >= MID) ? cmd - MID : MID - cmd;
    if (cur_mag > 2 * cmd_mag + `QLA_SAFETY_MARGIN)
        next_viol_run = run + 1;
    else
        next_viol_run = 0;              // compliant sample breaks it
endfunction

task automatic queue_check(input string name, input logic [31:0] exp, input logic [31:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
endtask

//----------------------------------------------------------------------
// APB transfers, driven on the falling edge
//----------------------------------------------------------------------
task automatic apb_access(input logic [7:0] addr, input logic write,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic slverr);
    int waited;
    waited = 0;
    @(negedge sysclk);
    paddr   = addr;         // setup phase
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge sysclk);
    penable = 1'b1;         // access phase
    #1;
    while (!pready && waited < APB_TIMEOUT) begin
        @(negedge sysclk);
        #1;
        waited++;
    end
    if (!pready) begin
        errors++;
        $display("APB access to %h timed out waiting for pready", addr);
    end
    rdata  = prdata;
    slverr = pslverr;
    @(negedge sysclk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(addr, 1'b1, data, rd, err);
    queue_check($sformatf("write %h pslverr", addr), 32'd0, {31'd0, err});
endtask

task automatic reg_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_access(addr, 1'b0, 32'd0, rd, err);
    queue_check(name, exp, rd);
    queue_check({name, " pslverr"}, 32'd0, {31'd0, err});
endtask

// unmapped access must flag pslverr and read zero
task automatic bad_access(input string name, input logic [7:0] addr, input logic write,
                          input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(addr, write, data, rd, err);
    queue_check({name, " pslverr"}, 32'd1, {31'd0, err});
    queue_check({name, " rdata"}, 32'd0, rd);
endtask

task automatic pulse_samples(input logic [`QLA_NUM_AXES-1:0][`QLA_CONV_WIDTH-1:0] fb);
    @(negedge sysclk);
    cur_fb    = fb;
    cur_ready = 1'b1;
    @(negedge sysclk);
    cur_ready = 1'b0;
    @(negedge sysclk);      // gap between samples
endtask

task automatic end_test(input int num, input string title);
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < 10) begin
        @(posedge sysclk);
        waited++;
    end
    if (exp_q.size() > 0) begin
        errors++;
        $display("compare process left %0d checks unprocessed", exp_q.size());
    end
    $display("test %0d %s: %0d errors", num, title, errors - err_mark);
    err_mark = errors;
endtask

`endif

/* test/tb_qla_ctrl.sv */
//----------------------------------------------------------------------
// testbench for the qla axis core
// APB register tests of board, feedback, encoder and safety paths
//----------------------------------------------------------------------

`timescale 1ns/1ns

`include "qla_settings.svh"

module tb_qla_ctrl;

    logic                                        sysclk;
    logic                                        reset;
    logic [`QLA_ADDR_WIDTH-1:0]                  paddr;
    logic                                        psel;
    logic                                        penable;
    logic                                        pwrite;
    logic [`QLA_DATA_WIDTH-1:0]                  pwdata;
    logic [`QLA_DATA_WIDTH-1:0]                  prdata;
    logic                                        pready;
    logic                                        pslverr;
    logic [3:0]                                  board_id_n;
    logic [`QLA_NUM_AXES-1:0][`QLA_CONV_WIDTH-1:0] cur_fb;
    logic                                        cur_ready;
    logic [`QLA_NUM_AXES-1:0]                    enc_a;
    logic [`QLA_NUM_AXES-1:0]                    enc_b;
    logic [`QLA_NUM_AXES-1:0][`QLA_CONV_WIDTH-1:0] cur_cmd;
    logic [`QLA_NUM_AXES-1:0]                    amp_enable;
    logic                                        pwr_enable;

    string       name_q[$];     // pending checks
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    int          errors   = 0;
    int          checks   = 0;
    int          err_mark = 0;

    `include "tb_qla_model.svh"

    qla_ctrl dut0 (
        .sysclk(sysclk), .reset(reset), .paddr(paddr), .psel(psel),
        .penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .board_id_n(board_id_n),
        .cur_fb(cur_fb), .cur_ready(cur_ready), .enc_a(enc_a), .enc_b(enc_b),
        .cur_cmd(cur_cmd), .amp_enable(amp_enable), .pwr_enable(pwr_enable)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;    // 4 ns period
    end

    // compare process, drains the check queue every cycle
    initial begin
        string       n;
        logic [31:0] e;
        logic [31:0] a;
        forever begin
            @(posedge sysclk);
            while (exp_q.size() > 0) begin
                n = name_q.pop_front();
                e = exp_q.pop_front();
                a = act_q.pop_front();
                checks++;
                if (e !== a) begin
                    errors++;
                    $display("error %s: expected %h, actual %h", n, e, a);
                end
            end
        end
    end

    initial begin
        #200000;
        $display("simulation watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    //------------------------------------------------------------------
    // stimulus
    //------------------------------------------------------------------
    initial begin
        logic [31:0]                  seed_val;
        logic [3:0]                   id;
        logic [3:0]                   dis;
        logic [`QLA_CONV_WIDTH-1:0]   cmd [1:4];
        logic [`QLA_NUM_AXES-1:0][`QLA_CONV_WIDTH-1:0] fb;
        logic [1:0]                   ab [0:3];
        logic [1:0]                   new_ab;
        logic [`QLA_ENC_WIDTH-1:0]    cnt [0:3];
        logic [31:0]                  pre;
        int                           k;
        int                           s;
        int                           t;
        int                           run;
        int                           waited;
        seed_val   = $urandom(32'hfcc4f1f0);
        reset      = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        board_id_n = 4'($urandom);
        cur_fb     = '0;
        cur_ready  = 1'b0;
        enc_a      = '0;
        enc_b      = '0;
        id         = ~board_id_n;
        repeat (5) @(negedge sysclk);
        reset = 1'b0;

        // 1: reset state
        reg_expect("status after reset", 8'h00, exp_status(4'h0, 1'b0, 4'h0, id));
        queue_check("amp_enable after reset", 32'd0, {28'd0, amp_enable});
        queue_check("pwr_enable after reset", 32'd0, {31'd0, pwr_enable});
        end_test(1, "reset state");

        // 2: command readback and feedback capture
        for (k = 1; k <= 4; k++) begin
            cmd[k] = 16'($urandom);
            reg_write(8'(k * 16 + 1), {16'h0, cmd[k]});
            reg_expect($sformatf("axis %0d cmd", k), 8'(k * 16 + 1), {16'h0, cmd[k]});
            queue_check($sformatf("axis %0d cur_cmd", k), {16'h0, cmd[k]},
                        {16'h0, cur_cmd[k - 1]});
            fb[k - 1] = 16'($urandom);
        end
        pulse_samples(fb);
        for (k = 1; k <= 4; k++)
            reg_expect($sformatf("axis %0d feedback", k), 8'(k * 16), {16'h0, fb[k - 1]});
        end_test(2, "command and feedback");

        // 3: quadrature steps, some held and some double changes
        for (k = 0; k < 4; k++) begin
            ab[k]  = 2'b00;
            cnt[k] = '0;
        end
        for (s = 0; s < 16; s++) begin
            @(negedge sysclk);
            for (k = 0; k < 4; k++) begin
                case ($urandom % 4)
                    0:       new_ab = ab_of_phase(enc_phase(ab[k]) + 1);
                    1:       new_ab = ab_of_phase(enc_phase(ab[k]) + 3);
                    2:       new_ab = ab[k];
                    default: new_ab = ab_of_phase(enc_phase(ab[k]) + 2);
                endcase
                enc_a[k] = new_ab[1];
                enc_b[k] = new_ab[0];
                cnt[k]   = exp_enc_count(cnt[k], ab[k], new_ab);
                ab[k]    = new_ab;
            end
            repeat (10) @(negedge sysclk);
        end
        for (k = 1; k <= 4; k++) begin
            reg_expect($sformatf("axis %0d count", k), 8'(k * 16 + 5), {8'h0, cnt[k - 1]});
            pre = $urandom;
            reg_write(8'(k * 16 + 4), pre);
            reg_expect($sformatf("axis %0d preload", k), 8'(k * 16 + 5), {8'h0, pre[23:0]});
            reg_expect($sformatf("axis %0d preload reg", k), 8'(k * 16 + 4),
                       {8'h0, pre[23:0]});
        end
        end_test(3, "encoder");

        // 4: overcurrent latch on one axis
        reg_write(8'h00, 32'h0f);       // requests without power
        queue_check("amp_enable without power", 32'd0, {28'd0, amp_enable});
        reg_write(8'h00, 32'h1f);
        for (k = 1; k <= 4; k++)
            reg_write(8'(k * 16 + 1), MID);
        queue_check("amp_enable on", 32'hf, {28'd0, amp_enable});
        queue_check("pwr_enable on", 32'd1, {31'd0, pwr_enable});
        t   = $urandom % 4;
        run = 0;
        dis = 4'h0;
        for (k = 0; k < 4; k++)
            fb[k] = 16'(MID);
        for (s = 0; s < 3 * `QLA_SAFETY_COUNT; s++) begin
            // two broken runs, then a full one
            if (s < 2 * `QLA_SAFETY_COUNT && (s % `QLA_SAFETY_COUNT) == `QLA_SAFETY_COUNT - 1)
                fb[t] = 16'(MID - 128 + ($urandom % 257));
            else if ($urandom % 2)
                fb[t] = 16'(MID + `QLA_SAFETY_MARGIN + 1 + ($urandom % 1000));
            else
                fb[t] = 16'(MID - `QLA_SAFETY_MARGIN - 1 - ($urandom % 1000));
            pulse_samples(fb);
            run = next_viol_run(run, fb[t], MID);
            if (run >= `QLA_SAFETY_COUNT)
                dis[t] = 1'b1;
            if (s == 2 * `QLA_SAFETY_COUNT - 1)
                queue_check("amp_enable after broken runs", {28'd0, 4'hf & ~dis},
                            {28'd0, amp_enable});
        end
        waited = 0;
        while (dis[t] && amp_enable[t] && waited < 10) begin
            @(negedge sysclk);
            waited++;
        end
        if (dis[t] && amp_enable[t]) begin
            errors++;
            $display("amp_enable %0d stayed high after the overcurrent run", t);
        end
        fb[t] = 16'(MID);               // latch holds through a compliant sample
        pulse_samples(fb);
        reg_expect("status tripped", 8'h00, exp_status(4'hf, 1'b1, dis, id));
        queue_check("amp_enable tripped", {28'd0, 4'hf & ~dis}, {28'd0, amp_enable});
        reg_write(8'h00, 32'h1f);       // rewriting the enable clears the latch
        reg_expect("status cleared", 8'h00, exp_status(4'hf, 1'b1, 4'h0, id));
        queue_check("amp_enable cleared", 32'hf, {28'd0, amp_enable});
        end_test(4, "safety latch");

        // 5: unmapped addresses
        bad_access("read chan 5", 8'h50, 1'b0, 32'd0);
        bad_access("write chan 6", 8'h61, 1'b1, $urandom);
        bad_access("write axis offset 2", 8'h12, 1'b1, $urandom);
        bad_access("write board offset 1", 8'h01, 1'b1, 32'd0);
        bad_access("write chan 15", 8'hf0, 1'b1, 32'd0);
        reg_expect("cmd unchanged", 8'h11, MID);
        reg_expect("axis 2 cmd unchanged", 8'h21, MID);
        reg_expect("status unchanged", 8'h00, exp_status(4'hf, 1'b1, 4'h0, id));
        end_test(5, "unmapped access");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+verilog
+incdir+test
verilog/qla_pkg.sv
verilog/apb_reg_bus.sv
verilog/board_regs.sv
verilog/quad_encoder.sv
verilog/safety_check.sv
verilog/axis_channel.sv
verilog/qla_ctrl.sv
test/tb_qla_ctrl.sv
